/* src/lane_pkg.sv */
/*
  Shared widths and types of the single vector lane.
  The VRF address is {register, element}, so VL_MAX must stay a power of two.
  The element tag is a flat vector. Use the TAG_* offsets to reach its fields.
*/
package lane_pkg;

  // Datapath and register file geometry
  localparam int unsigned ELEN     = 64;
  localparam int unsigned NR_VREGS = 8;
  localparam int unsigned VL_MAX   = 4;

  typedef logic [$clog2(NR_VREGS)-1:0]            vreg_t;
  typedef logic [$clog2(VL_MAX)-1:0]              eidx_t;
  typedef logic [$clog2(NR_VREGS*VL_MAX)-1:0]     vaddr_t;
  typedef logic [$clog2(VL_MAX+1)-1:0]            vl_t;

  typedef enum logic [2:0] {
    OP_ADD   = 3'd0,
    OP_SUB   = 3'd1,
    OP_AND   = 3'd2,
    OP_OR    = 3'd3,
    OP_XOR   = 3'd4,
    OP_STORE = 3'd5
  } alu_op_e;

  typedef enum logic {
    SEW32 = 1'b0,
    SEW64 = 1'b1
  } sew_e;

  // One element word, seen as one 64-bit or two 32-bit elements
  typedef union packed {
    logic [ELEN-1:0]           w64;
    logic [ELEN/32-1:0][31:0]  w32;
  } elem_word_u;

  // Tag layout, LSB first: last, element index, vd, sew, op
  localparam int unsigned TAG_LAST = 0;
  localparam int unsigned TAG_EIDX = TAG_LAST + 1;
  localparam int unsigned TAG_VD   = TAG_EIDX + $bits(eidx_t);
  localparam int unsigned TAG_SEW  = TAG_VD + $bits(vreg_t);
  localparam int unsigned TAG_OP   = TAG_SEW + 1;
  localparam int unsigned TAG_W    = TAG_OP + $bits(alu_op_e);

  typedef logic [TAG_W-1:0] elem_tag_t;

endpackage

/* src/lane_if.sv */
/*
  Handshake bundles inside the lane.
  Both follow valid/ready: valid stays up with stable payload until ready.
*/
`timescale 1ns/1ps

//////////////////////////////////////////////////
// Register read request, sequencer to queue
//////////////////////////////////////////////////

interface rd_req_if;
  import lane_pkg::*;

  logic      valid;
  logic      ready;
  vaddr_t    addr_a;
  vaddr_t    addr_b;
  elem_tag_t tag;

  modport seq (
    output valid, addr_a, addr_b, tag,
    input  ready
  );

  modport opq (
    input  valid, addr_a, addr_b, tag,
    output ready
  );

endinterface

//////////////////////////////////////////////////
// Operand pair, queue to ALU
//////////////////////////////////////////////////

interface operand_if;
  import lane_pkg::*;

  logic            valid;
  logic            ready;
  logic [ELEN-1:0] a;
  logic [ELEN-1:0] b;
  elem_tag_t       tag;

  modport opq (
    output valid, a, b, tag,
    input  ready
  );

  modport alu (
    input  valid, a, b, tag,
    output ready
  );

endinterface

/* src/lane_sequencer.sv */
/*
  Runs one instruction at a time and issues one element read per cycle.
  A new instruction is taken only after the done pulse of the previous one.
  vl must lie in 1..VL_MAX. A store reads its data from vs1.
*/
`timescale 1ns/1ps

module lane_sequencer (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              pe_req_valid_i,
  input  lane_pkg::alu_op_e pe_req_op_i,
  input  lane_pkg::sew_e    pe_req_sew_i,
  input  lane_pkg::vreg_t   pe_req_vd_i,
  input  lane_pkg::vreg_t   pe_req_vs1_i,
  input  lane_pkg::vreg_t   pe_req_vs2_i,
  input  lane_pkg::vl_t     pe_req_vl_i,
  output logic              pe_req_ready_o,
  input  logic              vinsn_done_i,
  rd_req_if.seq             rd_req_o
);
  import lane_pkg::*;

  logic    busy_q;
  logic    issue_q;
  eidx_t   eidx_q;
  alu_op_e op_q;
  sew_e    sew_q;
  vreg_t   vd_q;
  vreg_t   vs1_q;
  vreg_t   vs2_q;
  vl_t     vl_q;
  logic    accept;
  logic    rd_fire;
  logic    last_elem;

  assign pe_req_ready_o = ~busy_q;
  assign accept         = pe_req_valid_i & ~busy_q;
  assign rd_fire        = rd_req_o.valid & rd_req_o.ready;
  assign last_elem      = ({1'b0, eidx_q} == vl_q - vl_t'(1));

  // Busy from acceptance until the ALU retires the last element
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      issue_q <= 1'b0;
      eidx_q  <= '0;
    end else begin
      if (accept) begin
        busy_q  <= 1'b1;
        issue_q <= 1'b1;
        eidx_q  <= '0;
      end else begin
        if (vinsn_done_i) begin
          busy_q <= 1'b0;
        end
        if (rd_fire) begin
          if (last_elem) begin
            issue_q <= 1'b0;
          end else begin
            eidx_q <= eidx_q + eidx_t'(1);
          end
        end
      end
    end
  end

  // Instruction fields
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q  <= pe_req_op_i;
      sew_q <= pe_req_sew_i;
      vd_q  <= pe_req_vd_i;
      vs1_q <= pe_req_vs1_i;
      vs2_q <= pe_req_vs2_i;
      vl_q  <= pe_req_vl_i;
    end
  end

  assign rd_req_o.valid  = issue_q;
  assign rd_req_o.addr_a = {vs1_q, eidx_q};
  assign rd_req_o.addr_b = {vs2_q, eidx_q};
  // Packed in the TAG_* order of the package
  assign rd_req_o.tag    = {op_q, sew_q, vd_q, eidx_q, last_elem};

endmodule

/* src/vector_regfile.sv */
/*
  NR_VREGS x VL_MAX words of ELEN bits, no reset on the storage.
  Two read ports with one cycle of latency, one write port.
  The ALU always wins the write port; a load waits while the ALU writes.
*/
`timescale 1ns/1ps

module vector_regfile (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Read ports
  input  logic                      rd_i,
  input  lane_pkg::vaddr_t          rd_addr_a_i,
  input  lane_pkg::vaddr_t          rd_addr_b_i,
  output logic [lane_pkg::ELEN-1:0] rd_data_a_o,
  output logic [lane_pkg::ELEN-1:0] rd_data_b_o,
  // ALU write-back
  input  logic                      alu_we_i,
  input  lane_pkg::vaddr_t          alu_waddr_i,
  input  logic [lane_pkg::ELEN-1:0] alu_wdata_i,
  // Load write port
  input  logic                      ldu_req_i,
  input  lane_pkg::vaddr_t          ldu_addr_i,
  input  logic [lane_pkg::ELEN-1:0] ldu_wdata_i,
  output logic                      ldu_gnt_o
);
  import lane_pkg::*;

  localparam int unsigned NrWords = NR_VREGS * VL_MAX;

  logic [ELEN-1:0] mem_q [NrWords];
  logic            we;
  vaddr_t          waddr;
  logic [ELEN-1:0] wdata;
  logic [ELEN-1:0] rd_data_a_q;
  logic [ELEN-1:0] rd_data_b_q;

  //////////////////////////////////////////////////
  // Write arbitration
  //////////////////////////////////////////////////

  assign ldu_gnt_o = ldu_req_i & ~alu_we_i;
  assign we        = alu_we_i | ldu_gnt_o;
  assign waddr     = alu_we_i ? alu_waddr_i : ldu_addr_i;
  assign wdata     = alu_we_i ? alu_wdata_i : ldu_wdata_i;

  always_ff @(posedge clk_i) begin
    if (we) begin
      mem_q[waddr] <= wdata;
    end
  end

  //////////////////////////////////////////////////
  // Read ports
  //////////////////////////////////////////////////

  // Old data on a same-cycle read/write of one word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_data_a_q <= '0;
      rd_data_b_q <= '0;
    end else if (rd_i) begin
      rd_data_a_q <= mem_q[rd_addr_a_i];
      rd_data_b_q <= mem_q[rd_addr_b_i];
    end
  end

  assign rd_data_a_o = rd_data_a_q;
  assign rd_data_b_o = rd_data_b_q;

endmodule

/* src/operand_queue.sv */
/*
  Sends accepted reads to the VRF and queues the returned operand pairs.
  QueueDepth must be 2 or more. A read in flight counts as an occupied slot,
  so data returning from the VRF always finds room.
*/
`timescale 1ns/1ps

module operand_queue #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  rd_req_if.opq                     rd_req_i,
  output logic                      vrf_rd_o,
  output lane_pkg::vaddr_t          vrf_rd_addr_a_o,
  output lane_pkg::vaddr_t          vrf_rd_addr_b_o,
  input  logic [lane_pkg::ELEN-1:0] vrf_rd_data_a_i,
  input  logic [lane_pkg::ELEN-1:0] vrf_rd_data_b_i,
  operand_if.opq                    opnd_o
);
  import lane_pkg::*;

  localparam int unsigned PtrW = $clog2(QueueDepth);
  localparam int unsigned CntW = $clog2(QueueDepth + 1);
  localparam logic [PtrW-1:0] LastPtr = PtrW'(QueueDepth - 1);
  localparam logic [CntW:0]   DepthL  = (CntW + 1)'(QueueDepth);

  logic [ELEN-1:0] a_q   [QueueDepth];
  logic [ELEN-1:0] b_q   [QueueDepth];
  elem_tag_t       tag_q [QueueDepth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic [CntW:0]   occupancy;
  logic            inflight_q;
  elem_tag_t       inflight_tag_q;
  logic            push;
  logic            pop;

  // Read side
  assign occupancy       = {1'b0, count_q} + {{CntW{1'b0}}, inflight_q};
  assign rd_req_i.ready  = (occupancy < DepthL);
  assign vrf_rd_o        = rd_req_i.valid & rd_req_i.ready;
  assign vrf_rd_addr_a_o = rd_req_i.addr_a;
  assign vrf_rd_addr_b_o = rd_req_i.addr_b;

  // Tag waits one cycle for its data
  always_ff @(posedge clk_i) begin
    if (vrf_rd_o) begin
      inflight_tag_q <= rd_req_i.tag;
    end
  end

  assign push = inflight_q;
  assign pop  = opnd_o.valid & opnd_o.ready;

  always_ff @(posedge clk_i) begin
    if (push) begin
      a_q[wr_ptr_q]   <= vrf_rd_data_a_i;
      b_q[wr_ptr_q]   <= vrf_rd_data_b_i;
      tag_q[wr_ptr_q] <= inflight_tag_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inflight_q <= 1'b0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
    end else begin
      inflight_q <= vrf_rd_o;
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + PtrW'(1);
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + PtrW'(1);
      end
      count_q <= count_q + CntW'(push) - CntW'(pop);
    end
  end

  // Head of the queue
  assign opnd_o.valid = (count_q != '0);
  assign opnd_o.a     = a_q[rd_ptr_q];
  assign opnd_o.b     = b_q[rd_ptr_q];
  assign opnd_o.tag   = tag_q[rd_ptr_q];

endmodule

/* src/lane_alu.sv */
/*
  Integer ALU of the lane. Arithmetic and logic elements retire the cycle
  they are taken and are written straight to the VRF.
  Store elements leave through the store port and wait on its ready.
*/
`timescale 1ns/1ps

module lane_alu (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  operand_if.alu                    opnd_i,
  output logic                      vrf_we_o,
  output lane_pkg::vaddr_t          vrf_waddr_o,
  output logic [lane_pkg::ELEN-1:0] vrf_wdata_o,
  output logic [lane_pkg::ELEN-1:0] stu_operand_o,
  output logic                      stu_valid_o,
  input  logic                      stu_ready_i,
  output logic                      vinsn_done_o
);
  import lane_pkg::*;

  alu_op_e    op;
  sew_e       sew;
  vreg_t      vd;
  eidx_t      eidx;
  logic       last;
  logic       is_store;
  elem_word_u a_u;
  elem_word_u b_u;
  elem_word_u res_u;
  logic       done_q;

  // Tag fields
  assign op       = alu_op_e'(opnd_i.tag[TAG_OP +: $bits(alu_op_e)]);
  assign sew      = sew_e'(opnd_i.tag[TAG_SEW]);
  assign vd       = opnd_i.tag[TAG_VD +: $bits(vreg_t)];
  assign eidx     = opnd_i.tag[TAG_EIDX +: $bits(eidx_t)];
  assign last     = opnd_i.tag[TAG_LAST];
  assign is_store = (op == OP_STORE);

  assign a_u = opnd_i.a;
  assign b_u = opnd_i.b;

  // No carry or borrow crosses the 32-bit halves at SEW32
  always_comb begin
    res_u.w64 = '0;
    case (op)
      OP_ADD: begin
        if (sew == SEW64) begin
          res_u.w64 = a_u.w64 + b_u.w64;
        end else begin
          for (int i = 0; i < ELEN / 32; i++) begin
            res_u.w32[i] = a_u.w32[i] + b_u.w32[i];
          end
        end
      end
      OP_SUB: begin
        if (sew == SEW64) begin
          res_u.w64 = a_u.w64 - b_u.w64;
        end else begin
          for (int i = 0; i < ELEN / 32; i++) begin
            res_u.w32[i] = a_u.w32[i] - b_u.w32[i];
          end
        end
      end
      OP_AND:  res_u.w64 = a_u.w64 & b_u.w64;
      OP_OR:   res_u.w64 = a_u.w64 | b_u.w64;
      OP_XOR:  res_u.w64 = a_u.w64 ^ b_u.w64;
      default: res_u.w64 = '0;
    endcase
  end

  assign opnd_i.ready  = is_store ? stu_ready_i : 1'b1;

  assign vrf_we_o      = opnd_i.valid & ~is_store;
  assign vrf_waddr_o   = {vd, eidx};
  assign vrf_wdata_o   = res_u.w64;

  assign stu_valid_o   = opnd_i.valid & is_store;
  assign stu_operand_o = a_u.w64;

  // One-cycle done pulse after the last element retires
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_q <= 1'b0;
    end else begin
      done_q <= opnd_i.valid & opnd_i.ready & last;
    end
  end

  assign vinsn_done_o = done_q;

endmodule

/* src/lane.sv */
/*
  Single integer vector lane: sequencer, operand queue, VRF and ALU.
  One instruction at a time; pe_req_ready_o returns after vinsn_done_o.
  ldu_gnt_o is combinational and drops in cycles where the ALU writes.
*/
`timescale 1ns/1ps

module lane #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Instruction request
  input  logic                      pe_req_valid_i,
  input  lane_pkg::alu_op_e         pe_req_op_i,
  input  lane_pkg::sew_e            pe_req_sew_i,
  input  lane_pkg::vreg_t           pe_req_vd_i,
  input  lane_pkg::vreg_t           pe_req_vs1_i,
  input  lane_pkg::vreg_t           pe_req_vs2_i,
  input  lane_pkg::vl_t             pe_req_vl_i,
  output logic                      pe_req_ready_o,
  output logic                      vinsn_done_o,
  // Load port
  input  logic                      ldu_req_i,
  input  lane_pkg::vaddr_t          ldu_addr_i,
  input  logic [lane_pkg::ELEN-1:0] ldu_wdata_i,
  output logic                      ldu_gnt_o,
  // Store port
  output logic [lane_pkg::ELEN-1:0] stu_operand_o,
  output logic                      stu_valid_o,
  input  logic                      stu_ready_i
);
  import lane_pkg::*;

  rd_req_if  rd_req ();
  operand_if opnd ();

  logic            vrf_rd;
  vaddr_t          vrf_rd_addr_a;
  vaddr_t          vrf_rd_addr_b;
  logic [ELEN-1:0] vrf_rd_data_a;
  logic [ELEN-1:0] vrf_rd_data_b;
  logic            alu_we;
  vaddr_t          alu_waddr;
  logic [ELEN-1:0] alu_wdata;

  //////////////////////////////////////////////////
  // Sequencer and operand queue
  //////////////////////////////////////////////////

  lane_sequencer i_lane_sequencer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .pe_req_valid_i (pe_req_valid_i),
    .pe_req_op_i    (pe_req_op_i),
    .pe_req_sew_i   (pe_req_sew_i),
    .pe_req_vd_i    (pe_req_vd_i),
    .pe_req_vs1_i   (pe_req_vs1_i),
    .pe_req_vs2_i   (pe_req_vs2_i),
    .pe_req_vl_i    (pe_req_vl_i),
    .pe_req_ready_o (pe_req_ready_o),
    .vinsn_done_i   (vinsn_done_o),
    .rd_req_o       (rd_req.seq)
  );

  operand_queue #(
    .QueueDepth (QueueDepth)
  ) i_operand_queue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .rd_req_i        (rd_req.opq),
    .vrf_rd_o        (vrf_rd),
    .vrf_rd_addr_a_o (vrf_rd_addr_a),
    .vrf_rd_addr_b_o (vrf_rd_addr_b),
    .vrf_rd_data_a_i (vrf_rd_data_a),
    .vrf_rd_data_b_i (vrf_rd_data_b),
    .opnd_o          (opnd.opq)
  );

  //////////////////////////////////////////////////
  // Register file and ALU
  //////////////////////////////////////////////////

  vector_regfile i_vrf (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .rd_i        (vrf_rd),
    .rd_addr_a_i (vrf_rd_addr_a),
    .rd_addr_b_i (vrf_rd_addr_b),
    .rd_data_a_o (vrf_rd_data_a),
    .rd_data_b_o (vrf_rd_data_b),
    .alu_we_i    (alu_we),
    .alu_waddr_i (alu_waddr),
    .alu_wdata_i (alu_wdata),
    .ldu_req_i   (ldu_req_i),
    .ldu_addr_i  (ldu_addr_i),
    .ldu_wdata_i (ldu_wdata_i),
    .ldu_gnt_o   (ldu_gnt_o)
  );

  lane_alu i_lane_alu (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .opnd_i        (opnd.alu),
    .vrf_we_o      (alu_we),
    .vrf_waddr_o   (alu_waddr),
    .vrf_wdata_o   (alu_wdata),
    .stu_operand_o (stu_operand_o),
    .stu_valid_o   (stu_valid_o),
    .stu_ready_i   (stu_ready_i),
    .vinsn_done_o  (vinsn_done_o)
  );

endmodule

/* verif/lane_sva.sv */
/*
  Handshake and protocol checks, bound into every lane instance.
  Checks are idle while rst_ni is low.
*/
`timescale 1ns/1ps

module lane_sva (
  input logic                      clk_i,
  input logic                      rst_ni,
  input logic                      pe_req_valid_i,
  input logic                      pe_req_ready_o,
  input logic                      vinsn_done_o,
  input logic                      ldu_req_i,
  input logic                      ldu_gnt_o,
  input logic [lane_pkg::ELEN-1:0] stu_operand_o,
  input logic                      stu_valid_o,
  input logic                      stu_ready_i
);

  // Store data holds while stalled
  stu_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    stu_valid_o && !stu_ready_i |=> stu_valid_o && $stable(stu_operand_o))
    else $error("stu_valid_o dropped or stu_operand_o changed before stu_ready_i");

  accept_busy_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && pe_req_ready_o |=> !pe_req_ready_o)
    else $error("pe_req_ready_o high right after acceptance");

  busy_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pe_req_ready_o && !vinsn_done_o |=> !pe_req_ready_o)
    else $error("pe_req_ready_o rose without vinsn_done_o");

  done_pulse_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    vinsn_done_o |=> !vinsn_done_o)
    else $error("vinsn_done_o high for two cycles");

  gnt_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    ldu_gnt_o |-> ldu_req_i)
    else $error("ldu_gnt_o high without ldu_req_i");

endmodule

bind lane lane_sva lane_sva_i (
  .clk_i          (clk_i),
  .rst_ni         (rst_ni),
  .pe_req_valid_i (pe_req_valid_i),
  .pe_req_ready_o (pe_req_ready_o),
  .vinsn_done_o   (vinsn_done_o),
  .ldu_req_i      (ldu_req_i),
  .ldu_gnt_o      (ldu_gnt_o),
  .stu_operand_o  (stu_operand_o),
  .stu_valid_o    (stu_valid_o),
  .stu_ready_i    (stu_ready_i)
);

/* verif/lane_tb.sv */
/*
  Table-driven testbench of the vector lane with a shadow register model.
  Inputs change 2 ns after the rising edge and outputs are sampled on the
  falling edge. The first mismatch ends the run.
*/
`timescale 1ns/1ps

module lane_tb;
  import lane_pkg::*;

  localparam int unsigned PERIOD       = 40;
  localparam int unsigned RESET_CYCLES = 10;
  localparam int unsigned NUM_ROWS     = 13;
  localparam int unsigned TIMEOUT_NS   = (NUM_ROWS * 40 + RESET_CYCLES) * PERIOD;
  localparam logic [31:0] SEED         = 32'hc86d_60cb;

  typedef struct packed {
    alu_op_e op;
    sew_e    sew;
    vreg_t   vd;
    vreg_t   vs1;
    vreg_t   vs2;
    vl_t     vl;
  } row_t;

  logic            clk;
  logic            rst_n;
  logic            pe_req_valid;
  alu_op_e         pe_req_op;
  sew_e            pe_req_sew;
  vreg_t           pe_req_vd;
  vreg_t           pe_req_vs1;
  vreg_t           pe_req_vs2;
  vl_t             pe_req_vl;
  logic            pe_req_ready;
  logic            vinsn_done;
  logic            ldu_req;
  vaddr_t          ldu_addr;
  logic [ELEN-1:0] ldu_wdata;
  logic            ldu_gnt;
  logic [ELEN-1:0] stu_operand;
  logic            stu_valid;
  logic            stu_ready;

  logic [31:0]     rng;
  logic [ELEN-1:0] shadow [NR_VREGS][VL_MAX];
  logic [ELEN-1:0] exp_q [$];
  row_t            rows [NUM_ROWS];

  // Shallow queue so that store stalls reach the sequencer
  lane #(
    .QueueDepth (2)
  ) lane_i (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .pe_req_valid_i (pe_req_valid),
    .pe_req_op_i    (pe_req_op),
    .pe_req_sew_i   (pe_req_sew),
    .pe_req_vd_i    (pe_req_vd),
    .pe_req_vs1_i   (pe_req_vs1),
    .pe_req_vs2_i   (pe_req_vs2),
    .pe_req_vl_i    (pe_req_vl),
    .pe_req_ready_o (pe_req_ready),
    .vinsn_done_o   (vinsn_done),
    .ldu_req_i      (ldu_req),
    .ldu_addr_i     (ldu_addr),
    .ldu_wdata_i    (ldu_wdata),
    .ldu_gnt_o      (ldu_gnt),
    .stu_operand_o  (stu_operand),
    .stu_valid_o    (stu_valid),
    .stu_ready_i    (stu_ready)
  );

  always #(PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // Reference arithmetic with the halves computed separately at SEW32
  function automatic logic [ELEN-1:0] expected_result(input alu_op_e op, input sew_e sew,
                                                      input logic [ELEN-1:0] a,
                                                      input logic [ELEN-1:0] b);
    logic [31:0]     lo;
    logic [31:0]     hi;
    logic [ELEN-1:0] res;
    res = a;
    case (op)
      OP_ADD: begin
        lo  = a[31:0] + b[31:0];
        hi  = a[63:32] + b[63:32];
        res = (sew == SEW64) ? a + b : {hi, lo};
      end
      OP_SUB: begin
        lo  = a[31:0] - b[31:0];
        hi  = a[63:32] - b[63:32];
        res = (sew == SEW64) ? a - b : {hi, lo};
      end
      OP_AND:  res = a & b;
      OP_OR:   res = a | b;
      OP_XOR:  res = a ^ b;
      default: res = a;
    endcase
    return res;
  endfunction

  task automatic abort_run();
    $display("*** TEST FAILED ***");
    $fatal(1, "Stopped on the first error");
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Element 0 all ones and element 1 zero force wraparound and borrow
  task automatic load_reg(input vreg_t r, input int n, input logic edge_data);
    logic [31:0]     hi;
    logic [31:0]     lo;
    logic [ELEN-1:0] data;
    for (int e = 0; e < n; e++) begin
      hi   = next_rand();
      lo   = next_rand();
      data = {hi, lo};
      if (edge_data && e == 0) begin
        data = '1;
      end
      if (edge_data && e == 1) begin
        data = '0;
      end
      @(posedge clk);
      #2;
      ldu_req   = 1'b1;
      ldu_addr  = {r, eidx_t'(e)};
      ldu_wdata = data;
      @(negedge clk);
      check_eq("ldu_gnt_o", 64'(ldu_gnt), 64'd1);
      check_eq("vinsn_done_o", 64'(vinsn_done), 64'd0);
      shadow[r][e] = data;
    end
    @(posedge clk);
    #2;
    ldu_req = 1'b0;
  endtask

  // Issues one instruction and follows it to its done pulse
  task automatic run_insn(input alu_op_e op, input sew_e sew, input vreg_t vd,
                          input vreg_t vs1, input vreg_t vs2, input vl_t vl);
    int          n_stu;
    int          exp_count;
    logic        done_seen;
    logic [31:0] rnd;
    n_stu     = 0;
    exp_count = (op == OP_STORE) ? int'(vl) : 0;
    done_seen = 1'b0;
    @(negedge clk);
    check_eq("pe_req_ready_o", 64'(pe_req_ready), 64'd1);
    @(posedge clk);
    #2;
    pe_req_valid = 1'b1;
    pe_req_op    = op;
    pe_req_sew   = sew;
    pe_req_vd    = vd;
    pe_req_vs1   = vs1;
    pe_req_vs2   = vs2;
    pe_req_vl    = vl;
    @(posedge clk);
    #2;
    pe_req_valid = 1'b0;
    while (!done_seen) begin
      @(negedge clk);
      if (stu_valid && stu_ready) begin
        if (exp_q.size() == 0) begin
          $display("Error at %0t: store transfer with no element left to expect", $time);
          abort_run();
        end
        check_eq("stu_operand_o", stu_operand, exp_q.pop_front());
        n_stu++;
      end
      if (vinsn_done) begin
        done_seen = 1'b1;
      end else begin
        check_eq("pe_req_ready_o", 64'(pe_req_ready), 64'd0);
        @(posedge clk);
        #2;
        // Stall the store port about one cycle in four
        rnd       = next_rand();
        stu_ready = (rnd[1:0] != 2'b00);
      end
    end
    check_eq("stu transfer count", 64'(n_stu), 64'(exp_count));
    @(negedge clk);
    check_eq("vinsn_done_o", 64'(vinsn_done), 64'd0);
    check_eq("pe_req_ready_o", 64'(pe_req_ready), 64'd1);
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    row_t  row;
    vreg_t rd;
    clk          = 1'b0;
    rst_n        = 1'b0;
    pe_req_valid = 1'b0;
    pe_req_op    = OP_ADD;
    pe_req_sew   = SEW64;
    pe_req_vd    = '0;
    pe_req_vs1   = '0;
    pe_req_vs2   = '0;
    pe_req_vl    = vl_t'(1);
    ldu_req      = 1'b0;
    ldu_addr     = '0;
    ldu_wdata    = '0;
    stu_ready    = 1'b1;
    rng          = SEED;

    // op, sew, vd, vs1, vs2, vl
    rows[0]  = '{OP_STORE, SEW64, 3'd0, 3'd1, 3'd0, 3'd4};
    rows[1]  = '{OP_ADD,   SEW64, 3'd2, 3'd3, 3'd4, 3'd4};
    rows[2]  = '{OP_SUB,   SEW64, 3'd5, 3'd3, 3'd4, 3'd3};
    rows[3]  = '{OP_ADD,   SEW32, 3'd6, 3'd1, 3'd2, 3'd2};
    rows[4]  = '{OP_SUB,   SEW32, 3'd7, 3'd2, 3'd1, 3'd4};
    rows[5]  = '{OP_AND,   SEW64, 3'd0, 3'd5, 3'd6, 3'd1};
    rows[6]  = '{OP_OR,    SEW32, 3'd1, 3'd3, 3'd7, 3'd3};
    rows[7]  = '{OP_XOR,   SEW64, 3'd2, 3'd2, 3'd5, 3'd4};
    rows[8]  = '{OP_AND,   SEW32, 3'd3, 3'd1, 3'd4, 3'd2};
    rows[9]  = '{OP_XOR,   SEW32, 3'd4, 3'd6, 3'd7, 3'd2};
    rows[10] = '{OP_STORE, SEW32, 3'd0, 3'd5, 3'd0, 3'd1};
    rows[11] = '{OP_ADD,   SEW64, 3'd1, 3'd1, 3'd2, 3'd4};
    rows[12] = '{OP_OR,    SEW64, 3'd5, 3'd0, 3'd4, 3'd3};

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_eq("pe_req_ready_o", 64'(pe_req_ready), 64'd1);
    check_eq("stu_valid_o", 64'(stu_valid), 64'd0);
    check_eq("vinsn_done_o", 64'(vinsn_done), 64'd0);
    check_eq("ldu_gnt_o", 64'(ldu_gnt), 64'd0);

    for (int i = 0; i < NUM_ROWS; i++) begin
      row = rows[i];
      load_reg(row.vs1, int'(row.vl), 1'b1);
      load_reg(row.vs2, int'(row.vl), 1'b0);
      rd = row.vs1;
      if (row.op != OP_STORE) begin
        for (int e = 0; e < int'(row.vl); e++) begin
          shadow[row.vd][e] = expected_result(row.op, row.sew, shadow[row.vs1][e],
                                              shadow[row.vs2][e]);
        end
        run_insn(row.op, row.sew, row.vd, row.vs1, row.vs2, row.vl);
        rd = row.vd;
      end
      // Read the result back through the store port
      for (int e = 0; e < int'(row.vl); e++) begin
        exp_q.push_back(shadow[rd][e]);
      end
      run_insn(OP_STORE, row.sew, rd, rd, rd, row.vl);
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

  // Watchdog
  initial begin
    #(TIMEOUT_NS);
    $display("Error at %0t: the run timed out waiting on the DUT", $time);
    abort_run();
  end

endmodule

/* vlog.f */
src/lane_pkg.sv
src/lane_if.sv
src/lane_sequencer.sv
src/vector_regfile.sv
src/operand_queue.sv
src/lane_alu.sv
src/lane.sv
verif/lane_sva.sv
verif/lane_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --assert -j 0
TOP      = lane_tb
FILELIST = vlog.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee /dev/stderr | grep -q -F "*** TEST PASSED ***"

clean:
	rm -rf $(BUILD)
